//--- rtl/IntExecTypes.sv
// Shared definitions for the integer execution cluster
// Widths, lane count and instruction size
// Opcode and condition enums
// Issue, result and redirect structs

package IntExecTypes;

    localparam int DATA_WIDTH  = 32;
    localparam int LANE_COUNT  = 2;
    localparam int INSN_BYTES  = 4;
    localparam int OP_ID_WIDTH = 6;

    typedef logic [DATA_WIDTH-1:0] DataPath;
    typedef logic [OP_ID_WIDTH-1:0] OpId;

    // Functional unit class of a micro-op
    typedef enum logic [2:0] {
        OP_ALU,
        OP_SHIFT,
        OP_BRANCH,
        OP_JALR,
        OP_SELECT
    } IntOpType;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU
    } AluCode;

    typedef enum logic [1:0] {
        SH_SLL,
        SH_SRL,
        SH_SRA
    } ShiftCode;

    // Used by branches and by the select op
    typedef enum logic [2:0] {
        COND_EQ,
        COND_NE,
        COND_LT,
        COND_LTU,
        COND_GE,
        COND_GEU,
        COND_AL
    } CondCode;

    typedef struct packed {
        logic     valid;
        OpId      opId;
        IntOpType opType;
        AluCode   aluCode;
        ShiftCode shiftCode;
        CondCode  cond;
        DataPath  pc;
        DataPath  operandA;
        DataPath  operandB;       // Shift amount in the low bits
        DataPath  disp;
        logic     predTaken;
        DataPath  predAddr;
    } IntIssueOp;

    typedef struct packed {
        logic    valid;
        OpId     opId;
        DataPath data;
    } IntExecResult;

    typedef struct packed {
        OpId     opId;
        DataPath brAddr;
        DataPath nextAddr;
        logic    taken;
    } BranchRedirect;

endpackage

//--- rtl/IntAlu.sv
// Integer ALU and barrel shifter for one execution lane
// Arithmetic, logic and compare ops plus SLL, SRL and SRA

`timescale 1ns/1ps

module IntAlu (
    input  IntExecTypes::AluCode   aluCode,
    input  IntExecTypes::ShiftCode shiftCode,
    input  logic                   isShift,
    input  IntExecTypes::DataPath  opA,
    input  IntExecTypes::DataPath  opB,
    output IntExecTypes::DataPath  dataOut
);

    logic [$clog2(IntExecTypes::DATA_WIDTH)-1:0] shiftAmount;
    IntExecTypes::DataPath aluValue;
    IntExecTypes::DataPath shiftValue;

    assign shiftAmount = opB[$clog2(IntExecTypes::DATA_WIDTH)-1:0];

    always_comb begin
        case (aluCode)
            IntExecTypes::ALU_ADD:  aluValue = opA + opB;
            IntExecTypes::ALU_SUB:  aluValue = opA - opB;
            IntExecTypes::ALU_AND:  aluValue = opA & opB;
            IntExecTypes::ALU_OR:   aluValue = opA | opB;
            IntExecTypes::ALU_XOR:  aluValue = opA ^ opB;
            // Compares return 0 or 1
            IntExecTypes::ALU_SLT: begin
                aluValue = IntExecTypes::DataPath'($signed(opA) < $signed(opB));
            end
            IntExecTypes::ALU_SLTU: begin
                aluValue = IntExecTypes::DataPath'(opA < opB);
            end
            default: aluValue = opA + opB;
        endcase
    end

    always_comb begin
        case (shiftCode)
            IntExecTypes::SH_SLL: shiftValue = opA << shiftAmount;
            IntExecTypes::SH_SRL: shiftValue = opA >> shiftAmount;
            // Arithmetic shift keeps the sign bit
            IntExecTypes::SH_SRA: shiftValue = $signed(opA) >>> shiftAmount;
            default:              shiftValue = opA;
        endcase
    end

    assign dataOut = isShift ? shiftValue : aluValue;

endmodule

//--- rtl/BranchResolver.sv
// Branch resolution for one execution lane
// Condition check, target and link address, misprediction detection

`timescale 1ns/1ps

module BranchResolver (
    input  IntExecTypes::IntIssueOp op,
    output logic                    condTrue,
    output logic                    taken,
    output IntExecTypes::DataPath   nextAddr,
    output IntExecTypes::DataPath   linkAddr,
    output logic                    mispredict
);

    logic                  isBranch;
    IntExecTypes::DataPath target;

    always_comb begin
        case (op.cond)
            IntExecTypes::COND_EQ:  condTrue = (op.operandA == op.operandB);
            IntExecTypes::COND_NE:  condTrue = (op.operandA != op.operandB);
            IntExecTypes::COND_LT:  condTrue = ($signed(op.operandA) < $signed(op.operandB));
            IntExecTypes::COND_LTU: condTrue = (op.operandA < op.operandB);
            IntExecTypes::COND_GE:  condTrue = ($signed(op.operandA) >= $signed(op.operandB));
            IntExecTypes::COND_GEU: condTrue = (op.operandA >= op.operandB);
            IntExecTypes::COND_AL:  condTrue = 1'b1;
            default:                condTrue = 1'b1;
        endcase
    end

    assign isBranch = (op.opType == IntExecTypes::OP_BRANCH) ||
                      (op.opType == IntExecTypes::OP_JALR);

    // JALR is unconditional
    assign taken = (op.opType == IntExecTypes::OP_JALR) ||
                   (op.opType == IntExecTypes::OP_BRANCH && condTrue);

    always_comb begin
        if (op.opType == IntExecTypes::OP_JALR) begin
            // Register-indirect target with bit 0 cleared
            target = (op.operandA + op.disp) & ~IntExecTypes::DataPath'(1);
        end else begin
            target = op.pc + op.disp;
        end
    end

    assign linkAddr = op.pc + IntExecTypes::DataPath'(IntExecTypes::INSN_BYTES);
    assign nextAddr = taken ? target : linkAddr;

    // Wrong direction, or right direction with a wrong target
    assign mispredict = op.valid && isBranch &&
                        ((taken != op.predTaken) || (taken && op.predAddr != nextAddr));

endmodule

//--- rtl/IntExecLane.sv
// One integer execution lane
// Pipeline register, result selection by op type
// Pending redirect register and issue back-pressure

`timescale 1ns/1ps

module IntExecLane (
    input  logic                        clock,
    input  logic                        reset,
    input  IntExecTypes::IntIssueOp     issueOp,
    output logic                        issueReady,
    output IntExecTypes::IntExecResult  result,
    output logic                        redirectReq,
    output IntExecTypes::BranchRedirect redirectInfo,
    input  logic                        redirectDone
);

    logic                    pipeValid;
    IntExecTypes::IntIssueOp pipeOp;
    IntExecTypes::IntIssueOp curOp;
    IntExecTypes::DataPath   aluOut;
    IntExecTypes::DataPath   nextAddr;
    IntExecTypes::DataPath   linkAddr;
    logic                    condTrue;
    logic                    taken;
    logic                    mispredict;

    always_ff @(posedge clock) begin
        if (reset) begin
            pipeValid <= 1'b0;
        end else begin
            pipeValid <= issueOp.valid && issueReady;
        end
    end

    always_ff @(posedge clock) begin
        if (issueOp.valid && issueReady) begin
            pipeOp <= issueOp;
        end
    end

    // Stage view of the op with the registered valid bit
    always_comb begin
        curOp = pipeOp;
        curOp.valid = pipeValid;
    end

    IntAlu u_alu (
        .aluCode   (curOp.aluCode),
        .shiftCode (curOp.shiftCode),
        .isShift   (curOp.opType == IntExecTypes::OP_SHIFT),
        .opA       (curOp.operandA),
        .opB       (curOp.operandB),
        .dataOut   (aluOut)
    );

    BranchResolver u_branch (
        .op         (curOp),
        .condTrue   (condTrue),
        .taken      (taken),
        .nextAddr   (nextAddr),
        .linkAddr   (linkAddr),
        .mispredict (mispredict)
    );

    always_comb begin
        result.valid = curOp.valid;
        result.opId = curOp.opId;
        case (curOp.opType)
            IntExecTypes::OP_BRANCH, IntExecTypes::OP_JALR: result.data = linkAddr;
            IntExecTypes::OP_SELECT: begin
                result.data = condTrue ? curOp.operandA : curOp.operandB;
            end
            default: result.data = aluOut;
        endcase
    end

    // Request rises as the mispredicted branch leaves the stage
    always_ff @(posedge clock) begin
        if (reset) begin
            redirectReq <= 1'b0;
        end else if (mispredict) begin
            redirectReq <= 1'b1;
        end else if (redirectDone) begin
            redirectReq <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (mispredict) begin
            redirectInfo.opId <= curOp.opId;
            redirectInfo.brAddr <= curOp.pc;
            redirectInfo.nextAddr <= nextAddr;
            redirectInfo.taken <= taken;
        end
    end

    // Also stall while a mispredict sits in the stage, so none is lost
    assign issueReady = !redirectReq && !mispredict;

endmodule

//--- rtl/RedirectArbiter.sv
// Round-robin arbiter for the shared redirect bus
// Four-phase valid/ack handshake toward fetch, done pulse to the owning lane

`timescale 1ns/1ps

module RedirectArbiter (
    input  logic                                    clock,
    input  logic                                    reset,
    input  logic [IntExecTypes::LANE_COUNT-1:0]     redirectReq,
    input  IntExecTypes::BranchRedirect             redirectInfo [IntExecTypes::LANE_COUNT],
    output logic [IntExecTypes::LANE_COUNT-1:0]     redirectDone,
    output logic                                    redirectValid,
    output IntExecTypes::BranchRedirect             redirect,
    input  logic                                    redirectAck
);

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_WAIT_ACK,
        ARB_WAIT_RELEASE
    } ArbState;

    typedef logic [$clog2(IntExecTypes::LANE_COUNT)-1:0] LaneIdx;

    ArbState                     state;
    LaneIdx                      rrPtr;
    LaneIdx                      owner;
    LaneIdx                      pick;
    logic                        grant;
    IntExecTypes::BranchRedirect busData;

    // Search from the pointer, lowest offset wins
    always_comb begin
        pick = rrPtr;
        for (int k = IntExecTypes::LANE_COUNT - 1; k >= 0; k--) begin
            if (redirectReq[(int'(rrPtr) + k) % IntExecTypes::LANE_COUNT]) begin
                pick = LaneIdx'((int'(rrPtr) + k) % IntExecTypes::LANE_COUNT);
            end
        end
    end

    // Skip the cycle of a done pulse, the owner's request is still up
    assign grant = (state == ARB_IDLE) && (|redirectReq) && !(|redirectDone);

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= ARB_IDLE;
            rrPtr <= '0;
            owner <= '0;
            redirectValid <= 1'b0;
            redirectDone <= '0;
        end else begin
            redirectDone <= '0;
            case (state)
                ARB_IDLE: begin
                    if (grant) begin
                        owner <= pick;
                        rrPtr <= LaneIdx'((int'(pick) + 1) % IntExecTypes::LANE_COUNT);
                        redirectValid <= 1'b1;
                        state <= ARB_WAIT_ACK;
                    end
                end
                ARB_WAIT_ACK: begin
                    if (redirectAck) begin
                        redirectValid <= 1'b0;
                        state <= ARB_WAIT_RELEASE;
                    end
                end
                ARB_WAIT_RELEASE: begin
                    if (!redirectAck) begin
                        redirectDone[owner] <= 1'b1;
                        state <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // Bus data stays stable for the whole handshake
    always_ff @(posedge clock) begin
        if (grant) begin
            busData <= redirectInfo[pick];
        end
    end

    assign redirect = busData;

endmodule

//--- rtl/IntExecCluster.sv
// Two-lane integer execution cluster
// Lane instances and the redirect bus arbiter

`timescale 1ns/1ps

module IntExecCluster (
    input  logic                                clock,
    input  logic                                reset,
    input  IntExecTypes::IntIssueOp             issueOp    [IntExecTypes::LANE_COUNT],
    output logic [IntExecTypes::LANE_COUNT-1:0] issueReady,
    output IntExecTypes::IntExecResult          result     [IntExecTypes::LANE_COUNT],
    output logic                                redirectValid,
    output IntExecTypes::BranchRedirect         redirect,
    input  logic                                redirectAck
);

    logic [IntExecTypes::LANE_COUNT-1:0] redirectReq;
    logic [IntExecTypes::LANE_COUNT-1:0] redirectDone;
    IntExecTypes::BranchRedirect         redirectInfo [IntExecTypes::LANE_COUNT];

    for (genvar i = 0; i < IntExecTypes::LANE_COUNT; i++) begin : gLane
        IntExecLane u_lane (
            .clock        (clock),
            .reset        (reset),
            .issueOp      (issueOp[i]),
            .issueReady   (issueReady[i]),
            .result       (result[i]),
            .redirectReq  (redirectReq[i]),
            .redirectInfo (redirectInfo[i]),
            .redirectDone (redirectDone[i])
        );
    end

    // Single owner of the redirect bus toward fetch
    RedirectArbiter u_arbiter (
        .clock         (clock),
        .reset         (reset),
        .redirectReq   (redirectReq),
        .redirectInfo  (redirectInfo),
        .redirectDone  (redirectDone),
        .redirectValid (redirectValid),
        .redirect      (redirect),
        .redirectAck   (redirectAck)
    );

endmodule

//--- test/IntExecTests.svh
// Directed tests for the execution cluster testbench
// Reset state, ALU and shift, select, predicted branches and redirects

    task automatic checkResetState();
        @(negedge clock);
        expectEqual("reset", "issueReady", 32'h3, 32'(issueReady));
        expectEqual("reset", "redirectValid", 0, 32'(redirectValid));
        expectEqual("reset", "lane 0 result valid", 0, 32'(result[0].valid));
        expectEqual("reset", "lane 1 result valid", 0, 32'(result[1].valid));
    endtask

    task automatic runAluShiftOps();
        IntExecTypes::IntIssueOp op0;
        IntExecTypes::IntIssueOp op1;
        for (int k = 0; k < 7; k++) begin
            op0 = randomOp(6'(k), IntExecTypes::OP_ALU);
            op0.aluCode = IntExecTypes::AluCode'(k);
            op1 = randomOp(6'(k + 8), IntExecTypes::OP_ALU);
            op1.aluCode = IntExecTypes::AluCode'(6 - k);
            issueOps("aluShift", op0, op1);
        end
        for (int k = 0; k < 3; k++) begin
            op0 = randomOp(6'(k + 16), IntExecTypes::OP_SHIFT);
            op0.shiftCode = IntExecTypes::ShiftCode'(k);
            op1 = randomOp(6'(k + 20), IntExecTypes::OP_SHIFT);
            op1.shiftCode = IntExecTypes::ShiftCode'(2 - k);
            issueOps("aluShift", op0, op1);
        end
    endtask

    task automatic runSelectOps();
        IntExecTypes::IntIssueOp op0;
        IntExecTypes::IntIssueOp op1;
        for (int k = 0; k < 7; k++) begin
            op0 = randomOp(6'(k + 24), IntExecTypes::OP_SELECT);
            op0.cond = IntExecTypes::CondCode'(k);
            // Only the sign bit differs, so signed and unsigned compares disagree
            op1 = op0;
            op1.opId = 6'(k + 32);
            op1.operandB = op1.operandA ^ 32'h8000_0000;
            issueOps("select", op0, op1);
        end
    endtask

    task automatic runPredictedBranches();
        IntExecTypes::IntIssueOp op0;
        IntExecTypes::IntIssueOp op1;
        for (int k = 0; k < 8; k++) begin
            op0 = randomOp(6'(k + 40), IntExecTypes::OP_BRANCH);
            op0.cond = IntExecTypes::CondCode'(k % 7);
            if ((k % 2) == 1) begin
                op0.operandB = op0.operandA;
            end
            op0.predTaken = branchTaken(op0);
            op0.predAddr = predictNext(op0);
            op1 = randomOp(6'(k + 48), IntExecTypes::OP_JALR);
            op1.predTaken = 1'b1;
            op1.predAddr = predictNext(op1);
            issueOps("predicted", op0, op1);
            @(negedge clock);
            expectEqual("predicted", "redirectValid",
                        32'(predictMispredict(op0) || predictMispredict(op1)),
                        32'(redirectValid));
        end
    endtask

    task automatic runSingleRedirect();
        IntExecTypes::IntIssueOp     branchOp;
        IntExecTypes::IntIssueOp     aluOp;
        IntExecTypes::IntIssueOp     noOp;
        IntExecTypes::BranchRedirect seen;
        noOp = '0;
        // Always taken but predicted not taken
        branchOp = randomOp(6'd56, IntExecTypes::OP_BRANCH);
        branchOp.cond = IntExecTypes::COND_AL;
        branchOp.predTaken = 1'b0;
        issueOps("singleRedirect", noOp, branchOp);
        // Lane 0 keeps running while lane 1 waits on the bus
        for (int k = 0; k < 3; k++) begin
            aluOp = randomOp(6'(k + 57), IntExecTypes::OP_ALU);
            issueOps("singleRedirect", aluOp, noOp);
            expectEqual("singleRedirect", "lane 1 issueReady", 0, 32'(issueReady[1]));
        end
        serveRedirect(seen);
        expectRedirect("singleRedirect", branchOp, seen);
        @(negedge clock);
        expectEqual("singleRedirect", "lane 1 issueReady before done", 0, 32'(issueReady[1]));
        aluOp = randomOp(6'd0, IntExecTypes::OP_ALU);
        issueOps("singleRedirect", noOp, aluOp);
    endtask

    task automatic runDualRedirects();
        IntExecTypes::IntIssueOp     op0;
        IntExecTypes::IntIssueOp     op1;
        IntExecTypes::BranchRedirect seen;
        for (int round = 0; round < 2; round++) begin
            // Not taken, predicted taken
            op0 = randomOp(6'(60 + round), IntExecTypes::OP_BRANCH);
            op0.cond = IntExecTypes::COND_NE;
            op0.operandB = op0.operandA;
            op0.predTaken = 1'b1;
            op0.predAddr = op0.pc + op0.disp;
            // JALR with a stale target
            op1 = randomOp(6'(62 + round), IntExecTypes::OP_JALR);
            op1.predTaken = 1'b1;
            op1.predAddr = ~predictNext(op1);
            issueOps("dualRedirect", op0, op1);
            serveRedirect(seen);
            expectRedirect("dualRedirect lane 0", op0, seen);
            serveRedirect(seen);
            expectRedirect("dualRedirect lane 1", op1, seen);
        end
    endtask

//--- test/IntExecClusterTb.sv
// Testbench for the two-lane integer execution cluster
// Clock, reset, DUT instance, reference model and timeout
// Directed test tasks come from the included task file

`timescale 1ns/1ps

module IntExecClusterTb;

    localparam int TEST_COUNT      = 6;
    localparam int MAX_TEST_CYCLES = 300;
    // Margin on top of the longest expected run
    localparam int TIMEOUT_CYCLES  = TEST_COUNT * MAX_TEST_CYCLES + 1200;

    logic                                clock;
    logic                                reset;
    IntExecTypes::IntIssueOp             issueOp [IntExecTypes::LANE_COUNT];
    logic [IntExecTypes::LANE_COUNT-1:0] issueReady;
    IntExecTypes::IntExecResult          result [IntExecTypes::LANE_COUNT];
    logic                                redirectValid;
    IntExecTypes::BranchRedirect         redirect;
    logic                                redirectAck;
    integer                              seed = 32'h6bfb;
    int                                  cycleCount = 0;

    IntExecCluster u_dut (
        .clock         (clock),
        .reset         (reset),
        .issueOp       (issueOp),
        .issueReady    (issueReady),
        .result        (result),
        .redirectValid (redirectValid),
        .redirect      (redirect),
        .redirectAck   (redirectAck)
    );

    always #20 clock = ~clock;

    always @(posedge clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Regression failed");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    function automatic logic condHolds(IntExecTypes::CondCode cond,
                                       IntExecTypes::DataPath a, IntExecTypes::DataPath b);
        case (cond)
            IntExecTypes::COND_EQ:  return a == b;
            IntExecTypes::COND_NE:  return a != b;
            IntExecTypes::COND_LT:  return $signed(a) < $signed(b);
            IntExecTypes::COND_LTU: return a < b;
            IntExecTypes::COND_GE:  return $signed(a) >= $signed(b);
            IntExecTypes::COND_GEU: return a >= b;
            default:                return 1'b1;
        endcase
    endfunction

    function automatic IntExecTypes::DataPath predictData(IntExecTypes::IntIssueOp op);
        IntExecTypes::DataPath a;
        IntExecTypes::DataPath b;
        a = op.operandA;
        b = op.operandB;
        case (op.opType)
            IntExecTypes::OP_SHIFT: begin
                case (op.shiftCode)
                    IntExecTypes::SH_SLL: return a << b[4:0];
                    IntExecTypes::SH_SRL: return a >> b[4:0];
                    default:              return IntExecTypes::DataPath'($signed(a) >>> b[4:0]);
                endcase
            end
            // Link address of the branch
            IntExecTypes::OP_BRANCH, IntExecTypes::OP_JALR: return op.pc + 32'd4;
            IntExecTypes::OP_SELECT: return condHolds(op.cond, a, b) ? a : b;
            default: begin
                case (op.aluCode)
                    IntExecTypes::ALU_ADD: return a + b;
                    IntExecTypes::ALU_SUB: return a - b;
                    IntExecTypes::ALU_AND: return a & b;
                    IntExecTypes::ALU_OR:  return a | b;
                    IntExecTypes::ALU_XOR: return a ^ b;
                    IntExecTypes::ALU_SLT: return {31'b0, $signed(a) < $signed(b)};
                    // Remaining code is SLTU
                    default:               return {31'b0, a < b};
                endcase
            end
        endcase
    endfunction

    function automatic logic branchTaken(IntExecTypes::IntIssueOp op);
        return (op.opType == IntExecTypes::OP_JALR) ||
               (op.opType == IntExecTypes::OP_BRANCH && condHolds(op.cond, op.operandA,
                                                                  op.operandB));
    endfunction

    function automatic IntExecTypes::DataPath predictNext(IntExecTypes::IntIssueOp op);
        if (!branchTaken(op)) begin
            return op.pc + 32'd4;
        end
        if (op.opType == IntExecTypes::OP_JALR) begin
            return (op.operandA + op.disp) & 32'hFFFF_FFFE;
        end
        return op.pc + op.disp;
    endfunction

    function automatic logic predictMispredict(IntExecTypes::IntIssueOp op);
        logic isBranch;
        isBranch = (op.opType == IntExecTypes::OP_BRANCH) || (op.opType == IntExecTypes::OP_JALR);
        return isBranch && ((branchTaken(op) != op.predTaken) ||
                            (branchTaken(op) && op.predAddr != predictNext(op)));
    endfunction

    // Valid op of the given type with random operands and an aligned pc
    function automatic IntExecTypes::IntIssueOp randomOp(IntExecTypes::OpId id,
                                                         IntExecTypes::IntOpType opType);
        IntExecTypes::IntIssueOp op;
        op = '0;
        op.valid = 1'b1;
        op.opId = id;
        op.opType = opType;
        op.pc = $random(seed) & 32'hFFFF_FFFC;
        op.operandA = $random(seed);
        op.operandB = $random(seed);
        op.disp = $random(seed);
        return op;
    endfunction

    task automatic expectEqual(string testName, string what,
                               logic [31:0] expected, logic [31:0] actual);
        assert (actual === expected) else begin
            $display("Error: %s %s expected %h actual %h", testName, what, expected, actual);
            $display("Regression failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic expectRedirect(string testName, IntExecTypes::IntIssueOp op,
                                  IntExecTypes::BranchRedirect seen);
        expectEqual(testName, "redirect opId", 32'(op.opId), 32'(seen.opId));
        expectEqual(testName, "redirect brAddr", op.pc, seen.brAddr);
        expectEqual(testName, "redirect nextAddr", predictNext(op), seen.nextAddr);
        expectEqual(testName, "redirect taken", 32'(branchTaken(op)), 32'(seen.taken));
    endtask

    // Fetch-side responder for one four-phase handshake
    task automatic serveRedirect(output IntExecTypes::BranchRedirect seen);
        @(posedge clock);
        while (!redirectValid) begin
            @(posedge clock);
        end
        seen = redirect;
        redirectAck <= 1'b1;
        do begin
            @(posedge clock);
        end while (redirectValid);
        redirectAck <= 1'b0;
    endtask

    // Issue on the lanes whose op is valid, check results one cycle later
    task automatic issueOps(string testName, IntExecTypes::IntIssueOp op0,
                            IntExecTypes::IntIssueOp op1);
        IntExecTypes::IntIssueOp             ops [IntExecTypes::LANE_COUNT];
        logic [IntExecTypes::LANE_COUNT-1:0] want;
        ops[0] = op0;
        ops[1] = op1;
        want = {op1.valid, op0.valid};
        do begin
            @(negedge clock);
        end while ((issueReady & want) != want);
        @(posedge clock);
        issueOp[0] <= op0;
        issueOp[1] <= op1;
        @(posedge clock);
        issueOp[0].valid <= 1'b0;
        issueOp[1].valid <= 1'b0;
        @(negedge clock);
        for (int i = 0; i < IntExecTypes::LANE_COUNT; i++) begin
            expectEqual(testName, "result valid", 32'(want[i]), 32'(result[i].valid));
            if (want[i]) begin
                expectEqual(testName, "result opId", 32'(ops[i].opId), 32'(result[i].opId));
                expectEqual(testName, "result data", predictData(ops[i]), result[i].data);
            end
        end
        @(negedge clock);
        for (int i = 0; i < IntExecTypes::LANE_COUNT; i++) begin
            expectEqual(testName, "result valid after one cycle", 0, 32'(result[i].valid));
        end
    endtask

    `include "IntExecTests.svh"

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        redirectAck = 1'b0;
        issueOp[0] = '0;
        issueOp[1] = '0;
        repeat (5) @(posedge clock);
        reset <= 1'b0;
        checkResetState();
        runAluShiftOps();
        runSelectOps();
        runPredictedBranches();
        runSingleRedirect();
        runDualRedirects();
        $display("Regression passed");
        $finish;
    end

endmodule

//--- project.f
+incdir+test
rtl/IntExecTypes.sv
rtl/IntAlu.sv
rtl/BranchResolver.sv
rtl/IntExecLane.sv
rtl/RedirectArbiter.sv
rtl/IntExecCluster.sv
test/IntExecClusterTb.sv

//--- Makefile
# Verilator regression for the integer execution cluster

BUILD_DIR := build

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run the regression"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module IntExecClusterTb \
		-f project.f -Mdir $(BUILD_DIR) -o simv
	./$(BUILD_DIR)/simv

clean:
	rm -rf $(BUILD_DIR)
